// File: files.f
source/ifu_bus_pkg.sv
source/ifu_instr_pkg.sv
source/ifu_fetch_req.sv
source/ifu_fifo_slot.sv
source/ifu_instr_align.sv
source/ifu_prefetch_top.sv
verification/tb_clk_gen.sv
verification/ifu_prefetch_checker.sv
verification/tb_ifu_prefetch.sv

// File: Bender.yml
package:
  name: ifu_prefetch

sources:
  - files:
      - source/ifu_bus_pkg.sv
      - source/ifu_instr_pkg.sv
      - source/ifu_fetch_req.sv
      - source/ifu_fifo_slot.sv
      - source/ifu_instr_align.sv
      - source/ifu_prefetch_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/ifu_prefetch_checker.sv
      - verification/tb_ifu_prefetch.sv

// File: verification/tb_ifu_prefetch.sv
//////////////////////////////
// Prefetch testbench
// Memory model with random grant and response delays,
// directed tests against a model that walks the image
//////////////////////////////

`timescale 1ns/1ps

module tb_ifu_prefetch import ifu_bus_pkg::*, ifu_instr_pkg::*;;

  // Instruction counts per test
  localparam int N_ALIGNED = 20;
  localparam int N_MIXED   = 40;
  localparam int N_PRE     = 5;
  localparam int N_BRANCH  = 20;
  localparam int N_ERR     = 24;
  localparam int N_RANDOM  = 200;
  localparam int TOTAL     = N_ALIGNED + N_MIXED + N_PRE + N_BRANCH + N_ERR + N_RANDOM;
  localparam int WATCHDOG_CYCLES = TOTAL * 40;

  logic   clk;
  logic   rst_n;
  logic   branch;
  addr_t  branch_addr;
  logic   mem_req;
  addr_t  mem_addr;
  logic   mem_gnt = 1'b0;
  logic   mem_rvalid = 1'b0;
  word_t  mem_rdata = '0;
  logic   mem_err = 1'b0;
  logic   instr_valid;
  logic   instr_ready;
  addr_t  instr_addr;
  addr_t  instr_addr_next;
  instr_t instr_rdata;
  logic   instr_err;
  logic   instr_err_plus2;

  // 8 KB image of half-words and one error flag per word
  logic [15:0] img [4096];
  logic        err_map [2048];

  // Granted reads waiting for their response
  addr_t resp_addr_q [$];
  int    resp_due_q [$];
  int    cycle;
  int    gnt_hold;

  addr_t exp_addr;
  int    errors = 0;
  int    timeouts = 0;

  tb_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  ifu_prefetch_top dut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .branch_i          (branch),
    .branch_addr_i     (branch_addr),
    .mem_req_o         (mem_req),
    .mem_addr_o        (mem_addr),
    .mem_gnt_i         (mem_gnt),
    .mem_rvalid_i      (mem_rvalid),
    .mem_rdata_i       (mem_rdata),
    .mem_err_i         (mem_err),
    .instr_valid_o     (instr_valid),
    .instr_ready_i     (instr_ready),
    .instr_addr_o      (instr_addr),
    .instr_addr_next_o (instr_addr_next),
    .instr_rdata_o     (instr_rdata),
    .instr_err_o       (instr_err),
    .instr_err_plus2_o (instr_err_plus2)
  );

  bind ifu_prefetch_top ifu_prefetch_checker u_checker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .branch_i      (branch_i),
    .mem_req_i     (mem_req_o),
    .mem_addr_i    (mem_addr_o),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .out_cnt_i     (u_fetch_req.out_cnt_q),
    .instr_valid_i (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_addr_i  (instr_addr_o),
    .instr_rdata_i (instr_rdata_o),
    .instr_err_i   (instr_err_o)
  );

  //////////////////////////////
  // Memory model
  //////////////////////////////

  function automatic logic [15:0] half_at(input addr_t a);
    return img[a[12:1]];
  endfunction

  function automatic logic err_at(input addr_t a);
    return err_map[a[12:2]];
  endfunction

  // Grant 0 to 3 cycles after the last one, answer 1 to 4 cycles after grant
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_gnt    <= 1'b0;
      mem_rvalid <= 1'b0;
      cycle      = 0;
      gnt_hold   = 0;
    end else begin
      cycle++;
      if (mem_req && mem_gnt) begin
        resp_addr_q.push_back(mem_addr);
        resp_due_q.push_back(cycle + int'($urandom % 4));
        gnt_hold = $urandom % 4;
      end
      if (gnt_hold > 0) begin
        gnt_hold--;
        mem_gnt <= 1'b0;
      end else begin
        mem_gnt <= 1'b1;
      end
      // In order and at most one response per cycle
      if (resp_due_q.size() > 0 && resp_due_q[0] <= cycle) begin
        mem_rvalid <= 1'b1;
        mem_rdata  <= {half_at(resp_addr_q[0] + 2), half_at(resp_addr_q[0])};
        mem_err    <= err_at(resp_addr_q[0]);
        resp_addr_q.delete(0);
        resp_due_q.delete(0);
      end else begin
        mem_rvalid <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Expected stream and checks
  //////////////////////////////

  // Expected instruction at address a with its {err, err_plus2} bits
  function automatic void expect_at(input addr_t a, output instr_t rdata,
                                    output instr_kind_e kind, output logic [1:0] errs);
    logic e0;
    logic e1;
    e0    = err_at(a);
    e1    = err_at(a + 4);
    rdata = {half_at(a + 2), half_at(a)};
    // Faulty word is never taken as compressed
    kind  = (half_at(a) % 4 != QUAD_FULL && !e0) ? INSTR_COMPRESSED : INSTR_FULL;
    if (a[1] && kind == INSTR_FULL) begin
      errs = {e0 | e1, e1 & ~e0};
    end else begin
      errs = {e0, 1'b0};
    end
  endfunction

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_instr(input string name, input instr_t exp, input instr_t act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (act !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  // Checks every handshake until count instructions were taken
  task automatic run_stream(input string name, input int count, input bit rand_ready);
    int          got;
    instr_t      exp_rdata;
    instr_kind_e kind;
    logic [1:0]  exp_errs;
    addr_t       step;
    instr_t      mask;
    got = 0;
    while (got < count) begin
      @(posedge clk);
      if (instr_valid && instr_ready) begin
        expect_at(exp_addr, exp_rdata, kind, exp_errs);
        step = (kind == INSTR_COMPRESSED) ? addr_t'(2) : addr_t'(4);
        // Upper half of a compressed instruction is not defined
        mask = (kind == INSTR_COMPRESSED) ? 32'h0000_ffff : 32'hffff_ffff;
        check_addr({name, " addr"}, exp_addr, instr_addr);
        check_addr({name, " addr_next"}, exp_addr + step, instr_addr_next);
        check_err({name, " err"}, exp_errs, {instr_err, instr_err_plus2});
        if (!exp_errs[1]) begin
          check_instr({name, " rdata"}, exp_rdata & mask, instr_rdata & mask);
        end
        exp_addr = exp_addr + step;
        got++;
      end
      instr_ready <= rand_ready ? 1'($urandom % 2) : 1'b1;
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic branch_to(input addr_t target);
    @(posedge clk);
    branch      <= 1'b1;
    branch_addr <= target;
    exp_addr    = target & ~addr_t'(1);
    @(posedge clk);
    branch <= 1'b0;
  endtask

  task automatic aligned_full();
    // Every word starts a full instruction
    for (int i = 0; i < N_ALIGNED + 4; i++) begin
      img[(12'h100 + 4 * i) >> 1][1:0] = QUAD_FULL;
    end
    branch_to(32'h0000_0100);
    run_stream("aligned_full", N_ALIGNED, 1'b0);
  endtask

  task automatic mixed_sizes();
    branch_to(32'h0000_0200);
    run_stream("mixed", N_MIXED, 1'b0);
  endtask

  task automatic branch_mid_fetch();
    branch_to(32'h0000_0300);
    run_stream("pre_branch", N_PRE, 1'b0);
    // Reads to the old stream are still in flight here
    branch_to(32'h0000_0402);
    run_stream("unaligned_branch", N_BRANCH, 1'b0);
  endtask

  task automatic bus_error_marks();
    // Full instruction at 0x506 reaches into the faulty word at 0x508
    img[12'h506 >> 1][1:0] = QUAD_FULL;
    err_map[12'h508 >> 2]  = 1'b1;
    err_map[12'h520 >> 2]  = 1'b1;
    branch_to(32'h0000_0506);
    run_stream("bus_error", N_ERR, 1'b0);
    err_map[12'h508 >> 2] = 1'b0;
    err_map[12'h520 >> 2] = 1'b0;
  endtask

  task automatic random_backpressure();
    branch_to(32'h0000_0800);
    run_stream("random_ready", N_RANDOM, 1'b1);
    instr_ready <= 1'b1;
  endtask

  task automatic finish_run();
    $display("Closing report: %0d value errors, %0d assertion errors, %0d timeouts",
             errors, dut.u_checker.assert_errs, timeouts);
    if (errors == 0 && timeouts == 0 && dut.u_checker.assert_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(75));
    branch      = 1'b0;
    branch_addr = '0;
    instr_ready = 1'b1;
    exp_addr    = '0;
    for (int i = 0; i < 4096; i++) begin
      img[i] = 16'($urandom);
    end
    for (int i = 0; i < 2048; i++) begin
      err_map[i] = 1'b0;
    end
    @(posedge rst_n);
    aligned_full();
    mixed_sizes();
    branch_mid_fetch();
    bus_error_marks();
    random_backpressure();
    finish_run();
  end

  // Hang guard with a budget of 40 cycles per instruction
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    timeouts++;
    $display("Watchdog expired after %0d cycles, test did not complete", WATCHDOG_CYCLES);
    finish_run();
  end

endmodule

// File: verification/ifu_prefetch_checker.sv
//////////////////////////////
// Prefetch protocol checker
// Bus request hold, output stability under back-pressure
// and the number of reads in flight
//////////////////////////////

`timescale 1ns/1ps

module ifu_prefetch_checker import ifu_bus_pkg::*, ifu_instr_pkg::*; (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             branch_i,
  input logic             mem_req_i,
  input addr_t            mem_addr_i,
  input logic             mem_gnt_i,
  input logic             mem_rvalid_i,
  input logic [CNT_W-1:0] out_cnt_i,
  input logic             instr_valid_i,
  input logic             instr_ready_i,
  input addr_t            instr_addr_i,
  input instr_t           instr_rdata_i,
  input logic             instr_err_i
);

  // Number of failed assertions
  int unsigned assert_errs = 0;
  // Reads granted but not yet answered
  int unsigned in_flight_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight_q <= 0;
    end else begin
      in_flight_q <= in_flight_q + (mem_req_i & mem_gnt_i) - mem_rvalid_i;
    end
  end

  // Request and address frozen until the grant edge
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_i && !mem_gnt_i |=> mem_req_i && $stable(mem_addr_i))
    else begin
      $error("Memory request dropped or changed before its grant");
      assert_errs++;
    end

  // Upper half only belongs to a full instruction
  out_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      instr_valid_i && !instr_ready_i |=> branch_i ||
      (instr_valid_i && $stable(instr_addr_i) && $stable(instr_err_i) &&
       $stable(instr_rdata_i[15:0]) &&
       ((instr_rdata_i[1:0] != QUAD_FULL) || $stable(instr_rdata_i))))
    else begin
      $error("Instruction output changed while stalled");
      assert_errs++;
    end

  // Requester must have counted a read for every response
  rvalid_owed: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_rvalid_i |-> out_cnt_i != '0)
    else begin
      $error("Read response without an outstanding read");
      assert_errs++;
    end

  in_flight_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
      in_flight_q <= NUM_REQS)
    else begin
      $error("More reads in flight than the requester allows");
      assert_errs++;
    end

endmodule

// File: verification/tb_clk_gen.sv
//////////////////////////////
// Testbench clock and reset
// 4 ns clock, active-low reset held for 16 cycles
//////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD = 2;
  localparam int RST_CYCLES  = 16;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Release on a rising edge so the first active cycle is a full one
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: source/ifu_prefetch_top.sv
//////////////////////////////
// Instruction prefetch top
// Requester feeds a chain of FIFO slots,
// the aligner drains them into instructions
//////////////////////////////

`timescale 1ns/1ps

module ifu_prefetch_top import ifu_bus_pkg::*, ifu_instr_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   branch_i,
  input  addr_t  branch_addr_i,
  output logic   mem_req_o,
  output addr_t  mem_addr_o,
  input  logic   mem_gnt_i,
  input  logic   mem_rvalid_i,
  input  word_t  mem_rdata_i,
  input  logic   mem_err_i,
  output logic   instr_valid_o,
  input  logic   instr_ready_i,
  output addr_t  instr_addr_o,
  output addr_t  instr_addr_next_o,
  output instr_t instr_rdata_o,
  output logic   instr_err_o,
  output logic   instr_err_plus2_o
);

  logic                    fifo_clear;
  logic                    resp_valid;
  word_t                   resp_rdata;
  logic                    resp_err;
  logic [DEPTH-1:0]        slot_push;
  logic [DEPTH-1:0]        slot_valid;
  logic [DEPTH-1:0]        slot_pushed;
  word_t [DEPTH-1:0]       slot_rdata;
  logic [DEPTH-1:0]        slot_err;
  logic                    pop;

  // Feeder
  ifu_fetch_req u_fetch_req (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .slot_valid_i  (slot_valid),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .mem_err_i     (mem_err_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .fifo_clear_o  (fifo_clear),
    .resp_valid_o  (resp_valid),
    .resp_rdata_o  (resp_rdata),
    .resp_err_o    (resp_err),
    .slot_push_o   (slot_push)
  );

  //////////////////////////////
  // Slot chain, index 0 is the output end
  //////////////////////////////

  for (genvar i = 0; i < DEPTH; i++) begin : g_slot
    logic  up_valid;
    logic  up_pushed;
    word_t up_rdata;
    logic  up_err;
    logic  lo_valid;

    // Top slot has nothing above it
    if (i == DEPTH - 1) begin : g_top_end
      assign up_valid  = 1'b0;
      assign up_pushed = 1'b0;
      assign up_rdata  = '0;
      assign up_err    = 1'b0;
    end else begin : g_up
      assign up_valid  = slot_valid[i+1];
      assign up_pushed = slot_pushed[i+1];
      assign up_rdata  = slot_rdata[i+1];
      assign up_err    = slot_err[i+1];
    end

    // Bottom slot always has room below
    if (i == 0) begin : g_bot_end
      assign lo_valid = 1'b1;
    end else begin : g_lo
      assign lo_valid = slot_valid[i-1];
    end

    ifu_fifo_slot u_slot (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .clear_i        (fifo_clear),
      .pop_i          (pop),
      .push_i         (slot_push[i]),
      .in_rdata_i     (resp_rdata),
      .in_err_i       (resp_err),
      .lower_valid_i  (lo_valid),
      .upper_valid_i  (up_valid),
      .upper_pushed_i (up_pushed),
      .upper_rdata_i  (up_rdata),
      .upper_err_i    (up_err),
      .valid_o        (slot_valid[i]),
      .pushed_o       (slot_pushed[i]),
      .rdata_o        (slot_rdata[i]),
      .err_o          (slot_err[i])
    );
  end

  // Drainer
  ifu_instr_align u_instr_align (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .clear_i           (fifo_clear),
    .branch_addr_i     (branch_addr_i),
    .resp_valid_i      (resp_valid),
    .resp_rdata_i      (resp_rdata),
    .resp_err_i        (resp_err),
    .slot_valid_i      (slot_valid[1:0]),
    .slot_rdata_i      (slot_rdata[1:0]),
    .slot_err_i        (slot_err[1:0]),
    .instr_ready_i     (instr_ready_i),
    .pop_o             (pop),
    .instr_valid_o     (instr_valid_o),
    .instr_addr_o      (instr_addr_o),
    .instr_addr_next_o (instr_addr_next_o),
    .instr_rdata_o     (instr_rdata_o),
    .instr_err_o       (instr_err_o),
    .instr_err_plus2_o (instr_err_plus2_o)
  );

endmodule

// File: source/ifu_instr_align.sv
//////////////////////////////
// Instruction aligner
// Builds one instruction per handshake from the two lowest
// slots or the bus bypass, in aligned or half-word aligned
// position, and tracks the instruction address
//////////////////////////////

`timescale 1ns/1ps

module ifu_instr_align import ifu_bus_pkg::*, ifu_instr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        clear_i,
  input  addr_t       branch_addr_i,
  input  logic        resp_valid_i,
  input  word_t       resp_rdata_i,
  input  logic        resp_err_i,
  input  logic [1:0]  slot_valid_i,
  input  word_t [1:0] slot_rdata_i,
  input  logic [1:0]  slot_err_i,
  input  logic        instr_ready_i,
  output logic        pop_o,
  output logic        instr_valid_o,
  output addr_t       instr_addr_o,
  output addr_t       instr_addr_next_o,
  output instr_t      instr_rdata_o,
  output logic        instr_err_o,
  output logic        instr_err_plus2_o
);

  word_t       rdata, rdata_unaligned;
  logic        err, err_unaligned, err_plus2;
  logic        valid, valid_unaligned;
  logic        aligned_is_compressed, unaligned_is_compressed;
  instr_kind_e kind;
  logic        handshake;
  addr_t       addr_q, addr_d, addr_next;

  //////////////////////////////
  // Source selection
  //////////////////////////////

  // Slot 0 first, otherwise the response arriving this cycle
  assign rdata = slot_valid_i[0] ? slot_rdata_i[0] : resp_rdata_i;
  assign err   = slot_valid_i[0] ? slot_err_i[0] : resp_err_i;
  assign valid = slot_valid_i[0] | resp_valid_i;

  // Upper half of the source word, then the lower half of the next word
  assign rdata_unaligned = slot_valid_i[1] ?
      {slot_rdata_i[1][HALF_W-1:0], rdata[WORD_W-1:HALF_W]} :
      {resp_rdata_i[HALF_W-1:0], rdata[WORD_W-1:HALF_W]};

  // Data is unknown under an error, so the compressed test needs it clear
  assign aligned_is_compressed   = (rdata[1:0] != QUAD_FULL) & ~err;
  assign unaligned_is_compressed = (rdata[HALF_W+1:HALF_W] != QUAD_FULL) & ~err;

  // Second word only counts when the instruction reaches into it
  always_comb begin
    if (slot_valid_i[1]) begin
      err_unaligned = slot_err_i[0] | (slot_err_i[1] & ~unaligned_is_compressed);
    end else begin
      err_unaligned = (slot_valid_i[0] & slot_err_i[0]) |
                      (resp_err_i & (~slot_valid_i[0] | ~unaligned_is_compressed));
    end
  end

  // Error that belongs only to the upper half of a split instruction
  always_comb begin
    if (slot_valid_i[1]) begin
      err_plus2 = slot_err_i[1] & ~slot_err_i[0];
    end else begin
      err_plus2 = resp_err_i & slot_valid_i[0] & ~slot_err_i[0];
    end
    err_plus2 = err_plus2 & ~unaligned_is_compressed;
  end

  // Split full instruction needs both words present
  assign valid_unaligned = slot_valid_i[1] | (slot_valid_i[0] & resp_valid_i);

  //////////////////////////////
  // Output forming
  //////////////////////////////

  always_comb begin
    if (addr_q[1]) begin
      kind = unaligned_is_compressed ? INSTR_COMPRESSED : INSTR_FULL;
    end else begin
      kind = aligned_is_compressed ? INSTR_COMPRESSED : INSTR_FULL;
    end
  end

  always_comb begin
    if (addr_q[1]) begin
      instr_rdata_o     = rdata_unaligned;
      instr_err_o       = err_unaligned;
      instr_err_plus2_o = err_plus2;
      instr_valid_o     = (kind == INSTR_FULL) ? valid_unaligned : valid;
    end else begin
      instr_rdata_o     = rdata;
      instr_err_o       = err;
      instr_err_plus2_o = 1'b0;
      instr_valid_o     = valid;
    end
    // Nothing from the old stream leaves during a branch
    instr_valid_o = instr_valid_o & ~clear_i;
  end

  assign handshake = instr_valid_o & instr_ready_i;

  // Word is used up by a full aligned instruction or any unaligned one
  assign pop_o = handshake & ((kind == INSTR_FULL) | addr_q[1]);

  //////////////////////////////
  // Instruction address
  //////////////////////////////

  assign addr_next = addr_q + ((kind == INSTR_COMPRESSED) ?
                               addr_t'(STEP_COMPRESSED) : addr_t'(STEP_FULL));

  // Addresses are half-word aligned, bit 0 is dropped
  assign addr_d = clear_i ? (branch_addr_i & ~addr_t'(1)) : addr_next;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (clear_i || handshake) begin
      addr_q <= addr_d;
    end
  end

  assign instr_addr_o      = addr_q;
  assign instr_addr_next_o = addr_next;

endmodule

// File: source/ifu_fifo_slot.sv
//////////////////////////////
// Prefetch FIFO slot
// Holds one fetched word with its error bit,
// takes a push or shifts down from above
//////////////////////////////

`timescale 1ns/1ps

module ifu_fifo_slot import ifu_bus_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  pop_i,
  input  logic  push_i,
  input  word_t in_rdata_i,
  input  logic  in_err_i,
  input  logic  lower_valid_i,
  input  logic  upper_valid_i,
  input  logic  upper_pushed_i,
  input  word_t upper_rdata_i,
  input  logic  upper_err_i,
  output logic  valid_o,
  output logic  pushed_o,
  output word_t rdata_o,
  output logic  err_o
);

  logic  valid_q, valid_d;
  logic  push_ok;
  logic  data_en;
  word_t rdata_q, rdata_d;
  logic  err_q, err_d;

  // A slot only fills above a valid neighbour, keeping the array contiguous
  assign push_ok = push_i & lower_valid_i;

  // Valid after this cycle's push, before any shift
  assign pushed_o = valid_q | push_ok;

  // Pop shifts the upper contents down, clear wins over everything
  assign valid_d = (pop_i ? upper_pushed_i : pushed_o) & ~clear_i;

  // Load on a shift from above or on a push that stays here
  assign data_en = (pop_i & upper_pushed_i) | (push_ok & ~pop_i);

  // Upper neighbour if it held data, else the word coming from the bus
  assign rdata_d = upper_valid_i ? upper_rdata_i : in_rdata_i;
  assign err_d   = upper_valid_i ? upper_err_i : in_err_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_en) begin
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  assign valid_o = valid_q;
  assign rdata_o = rdata_q;
  assign err_o   = err_q;

endmodule

// File: source/ifu_fetch_req.sv
//////////////////////////////
// Fetch requester
// Issues word reads on the memory bus, counts reads in flight,
// drops responses older than a branch and picks the FIFO slot
// for each surviving response
//////////////////////////////

`timescale 1ns/1ps

module ifu_fetch_req import ifu_bus_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             branch_i,
  input  addr_t            branch_addr_i,
  input  logic [DEPTH-1:0] slot_valid_i,
  input  logic             mem_gnt_i,
  input  logic             mem_rvalid_i,
  input  word_t            mem_rdata_i,
  input  logic             mem_err_i,
  output logic             mem_req_o,
  output addr_t            mem_addr_o,
  output logic             fifo_clear_o,
  output logic             resp_valid_o,
  output word_t            resp_rdata_o,
  output logic             resp_err_o,
  output logic [DEPTH-1:0] slot_push_o
);

  fetch_state_e     state_q, state_d;
  addr_t            fetch_addr_q, fetch_addr_d;
  addr_t            redir_addr_q, redir_addr_d;
  addr_t            target_addr, issue_addr;
  logic             redir_q, redir_d;
  logic [CNT_W-1:0] out_cnt_q, out_cnt_d;
  logic [CNT_W-1:0] drop_cnt_q, drop_cnt_d;
  logic             room, issue_en, gnt_ok, stale_gnt, drop_hit;
  logic [DEPTH-1:0] lowest_free;

  //////////////////////////////
  // Request control
  //////////////////////////////

  // Branch targets are fetched as whole words
  assign target_addr = branch_addr_i & ~addr_t'(3);
  assign issue_addr  = branch_i ? target_addr : fetch_addr_q;

  // Every read in flight must find a free slot on return
  always_comb begin : room_calc
    int unsigned fill;
    fill = 0;
    for (int i = 0; i < DEPTH; i++) begin
      fill += slot_valid_i[i];
    end
    // Slots are wiped on a branch
    if (branch_i) begin
      fill = 0;
    end
    room = (out_cnt_q < NUM_REQS) && ((fill + out_cnt_q) < DEPTH);
  end

  // New request from a free state, on a branch or while fetching on
  assign issue_en = room & (branch_i | (state_q == FETCH_FULL));

  always_comb begin
    state_d      = state_q;
    fetch_addr_d = fetch_addr_q;
    redir_d      = redir_q;
    redir_addr_d = redir_addr_q;
    mem_req_o    = 1'b0;
    mem_addr_o   = fetch_addr_q;
    unique case (state_q)
      FETCH_REQ: begin
        // Held request, address frozen until granted
        mem_req_o = 1'b1;
        if (mem_gnt_i) begin
          state_d      = FETCH_FULL;
          fetch_addr_d = redir_q ? redir_addr_q : fetch_addr_q + addr_t'(4);
          redir_d      = 1'b0;
        end
      end
      FETCH_IDLE, FETCH_FULL: begin
        mem_req_o  = issue_en;
        mem_addr_o = issue_addr;
        if (issue_en) begin
          state_d      = mem_gnt_i ? FETCH_FULL : FETCH_REQ;
          fetch_addr_d = mem_gnt_i ? issue_addr + addr_t'(4) : issue_addr;
        end else if (branch_i) begin
          // No room yet, start at the target once reads drain
          state_d      = FETCH_FULL;
          fetch_addr_d = target_addr;
        end
      end
      default: begin
        state_d = FETCH_IDLE;
      end
    endcase
    // Branch while an older request is still held on the bus
    if (branch_i && (state_q == FETCH_REQ)) begin
      if (mem_gnt_i) begin
        fetch_addr_d = target_addr;
      end else begin
        redir_d      = 1'b1;
        redir_addr_d = target_addr;
      end
    end
  end

  //////////////////////////////
  // Outstanding and drop counts
  //////////////////////////////

  assign gnt_ok = mem_req_o & mem_gnt_i;
  // Grant of a request that was raised before the branch
  assign stale_gnt = gnt_ok & (state_q == FETCH_REQ) & (branch_i | redir_q);
  assign drop_hit  = mem_rvalid_i & (drop_cnt_q != '0);

  assign out_cnt_d = out_cnt_q + CNT_W'(gnt_ok) - CNT_W'(mem_rvalid_i);

  always_comb begin
    if (branch_i) begin
      // Everything still in flight after this edge is stale
      drop_cnt_d = out_cnt_q - CNT_W'(mem_rvalid_i) + CNT_W'(stale_gnt);
    end else begin
      drop_cnt_d = drop_cnt_q - CNT_W'(drop_hit) + CNT_W'(stale_gnt);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= FETCH_IDLE;
      fetch_addr_q <= '0;
      redir_q      <= 1'b0;
      out_cnt_q    <= '0;
      drop_cnt_q   <= '0;
    end else begin
      state_q      <= state_d;
      fetch_addr_q <= fetch_addr_d;
      redir_q      <= redir_d;
      out_cnt_q    <= out_cnt_d;
      drop_cnt_q   <= drop_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    redir_addr_q <= redir_addr_d;
  end

  //////////////////////////////
  // Response forwarding
  //////////////////////////////

  assign fifo_clear_o = branch_i;
  assign resp_valid_o = mem_rvalid_i & ~drop_hit & ~branch_i;
  assign resp_rdata_o = mem_rdata_i;
  assign resp_err_o   = mem_err_i;

  // Write pointer is the lowest invalid slot above a valid one
  for (genvar i = 0; i < DEPTH; i++) begin : g_free
    if (i == 0) begin : g_first
      assign lowest_free[i] = ~slot_valid_i[i];
    end else begin : g_rest
      assign lowest_free[i] = ~slot_valid_i[i] & slot_valid_i[i-1];
    end
  end

  assign slot_push_o = lowest_free & {DEPTH{resp_valid_o}};

endmodule

// File: source/ifu_instr_pkg.sv
//////////////////////////////
// Instruction format package
// Instruction width, the encodings of the
// compressed test and the instruction kind
//////////////////////////////

package ifu_instr_pkg;

  // Full instruction width and one half-word
  localparam int unsigned INSTR_W = 32;
  localparam int unsigned HALF_W = 16;

  // Low two bits of a 32-bit instruction
  localparam logic [1:0] QUAD_FULL = 2'b11;

  // Address step per instruction kind
  localparam int unsigned STEP_COMPRESSED = 2;
  localparam int unsigned STEP_FULL = 4;

  typedef logic [INSTR_W-1:0] instr_t;

  // Size class of the instruction at the current address
  typedef enum logic {
    INSTR_COMPRESSED,
    INSTR_FULL
  } instr_kind_e;

endpackage

// File: source/ifu_bus_pkg.sv
//////////////////////////////
// Prefetch memory bus package
// Widths of the fetch bus, the read depth
// and the requester state encoding
//////////////////////////////

package ifu_bus_pkg;

  // Address and data widths of the fetch bus
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned WORD_W = 32;

  // Largest number of reads in flight
  localparam int unsigned NUM_REQS = 2;
  // One extra slot so a partly used word can wait for its upper half
  localparam int unsigned DEPTH = NUM_REQS + 1;
  // Width of the outstanding and drop counters
  localparam int unsigned CNT_W = $clog2(NUM_REQS + 1);

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;

  // Requester state
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_REQ,
    FETCH_FULL
  } fetch_state_e;

endpackage
